//--- design/alu_config.svh
// Build-time sizes and fixed exception codes for the ALU lane
// ALU_WID above 62 would overflow the 6-bit cycle counter used for divides
// ALU_MUL_STAGES must be at least 1

`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand and result width
`define ALU_WID 32

// Register stages in the multiplier, which is also its latency
`define ALU_MUL_STAGES 3

// Exception raised by a divide or remainder with a zero divisor
`define ALU_EXC_DBZ 8'h10

`endif

//--- design/alu_pkg.sv
// Types and modifier codes shared by the ALU lane
// The meaning of a modifier depends on the operation it travels with

package alu_pkg;

	// ========================================
	// Operations
	// ========================================
	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SET, OP_MINMAX,
		OP_MUL, OP_MULU,
		OP_DIV, OP_DIVU, OP_MOD, OP_MODU,
		OP_CHK
	} alu_op_e;

	typedef logic [2:0] alu_mod_t;

	// Combine step with c for the arithmetic and logic ops
	localparam alu_mod_t MOD_AND_C  = 3'd0;
	localparam alu_mod_t MOD_ANDN_C = 3'd1;
	localparam alu_mod_t MOD_OR_C   = 3'd2;
	localparam alu_mod_t MOD_XOR_C  = 3'd3;
	localparam alu_mod_t MOD_ADD_C  = 3'd4;
	localparam alu_mod_t MOD_NONE   = 3'd7;

	// Comparison selectors for OP_SET
	localparam alu_mod_t SET_EQ  = 3'd0;
	localparam alu_mod_t SET_NE  = 3'd1;
	localparam alu_mod_t SET_LT  = 3'd2;
	localparam alu_mod_t SET_LE  = 3'd3;
	localparam alu_mod_t SET_LTU = 3'd4;
	localparam alu_mod_t SET_LEU = 3'd5;

	// OP_MINMAX selectors
	localparam alu_mod_t MM_MIN  = 3'd0;
	localparam alu_mod_t MM_MAX  = 3'd1;
	localparam alu_mod_t MM_MINU = 3'd2;
	localparam alu_mod_t MM_MAXU = 3'd3;

	// OP_CHK range modes, [b,c) and [b,c]
	localparam alu_mod_t CHK_HALF_OPEN = 3'd0;
	localparam alu_mod_t CHK_CLOSED    = 3'd1;

	// ========================================
	// Flags, exceptions and FSM states
	// ========================================
	typedef struct packed {
		logic eq;
		logic lt;
		logic le;
		logic ltu;
		logic leu;
		logic ne;
	} cmp_t;

	typedef logic [7:0] exc_t;
	localparam exc_t EXC_NONE = 8'h00;

	typedef enum logic [1:0] {S_IDLE, S_WAIT_MUL, S_WAIT_DIV} alu_state_e;

endpackage

//--- design/alu_op_if.sv
// One issued operation as seen by the data modules
// Contents are only meaningful in the cycle where ld is high

`include "alu_config.svh"

interface alu_op_if;
	import alu_pkg::*;

	alu_op_e op;
	alu_mod_t mod;
	logic [`ALU_WID-1:0] a;
	logic [`ALU_WID-1:0] b;
	logic [`ALU_WID-1:0] c;
	logic [`ALU_WID-1:0] imm;

	// The top level fills the bundle from its input ports
	modport src (output op, mod, a, b, c, imm);

	// Every consumer only reads
	modport unit (input op, mod, a, b, c, imm);

endinterface

//--- design/alu_cmp.sv
// Signed and unsigned relations of a against b
// Purely combinational, one instance per operand pair

`include "alu_config.svh"

module alu_cmp (
	input logic [`ALU_WID-1:0] a,
	input logic [`ALU_WID-1:0] b,
	output alu_pkg::cmp_t flags
);

	logic eq;
	logic lt;
	logic ltu;

	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	// The less-or-equal forms reuse the strict compare and equality
	always_comb
	begin
		flags.eq = eq;
		flags.ne = !eq;
		flags.lt = lt;
		flags.le = lt || eq;
		flags.ltu = ltu;
		flags.leu = ltu || eq;
	end

endmodule

//--- design/alu_logic.sv
// Single-cycle results and the bounds-check exception
// Combinational; the result is registered by the issue FSM
// Multiply and divide ops give zero here and are served by their own units
// The bounds check compares unsigned

`include "alu_config.svh"

module alu_logic (
	alu_op_if.unit opi,
	output logic [`ALU_WID-1:0] res,
	output alu_pkg::exc_t exc
);
	import alu_pkg::*;

	cmp_t flags;
	cmp_t flags_ac;
	cmp_t flags_bc;
	logic [`ALU_WID-1:0] prim;
	logic set_hit;
	logic in_range;

	alu_cmp cmp_ab_i (.a(opi.a), .b(opi.b), .flags(flags));
	alu_cmp cmp_ac_i (.a(opi.a), .b(opi.c), .flags(flags_ac));
	alu_cmp cmp_bc_i (.a(opi.b), .b(opi.c), .flags(flags_bc));

	// Primary result before the c combine step
	always_comb
	begin
		case (opi.op)
			OP_SUB: prim = opi.a - opi.b;
			OP_AND: prim = opi.a & opi.b;
			OP_OR: prim = opi.a | opi.b;
			OP_XOR: prim = opi.a ^ opi.b;
			default: prim = opi.a + opi.b;
		endcase
	end

	always_comb
	begin
		case (opi.mod)
			SET_EQ: set_hit = flags.eq;
			SET_NE: set_hit = flags.ne;
			SET_LT: set_hit = flags.lt;
			SET_LE: set_hit = flags.le;
			SET_LTU: set_hit = flags.ltu;
			SET_LEU: set_hit = flags.leu;
			default: set_hit = 1'b0;
		endcase
	end

	// Lower bound is b, upper bound is c; reserved modes always fail
	always_comb
	begin
		case (opi.mod)
			CHK_HALF_OPEN: in_range = !flags.ltu && flags_ac.ltu;
			CHK_CLOSED: in_range = !flags.ltu && flags_ac.leu;
			default: in_range = 1'b0;
		endcase
	end

	// ========================================
	// Result select
	// ========================================
	always_comb
	begin
		res = '0;
		exc = EXC_NONE;
		case (opi.op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
				case (opi.mod)
					MOD_AND_C: res = prim & opi.c;
					MOD_ANDN_C: res = prim & ~opi.c;
					MOD_OR_C: res = prim | opi.c;
					MOD_XOR_C: res = prim ^ opi.c;
					// Subtract chains a second subtract of c
					MOD_ADD_C: res = (opi.op == OP_SUB) ? prim - opi.c : prim + opi.c;
					MOD_NONE: res = prim;
					default: res = prim;
				endcase
			OP_SET:
				res = set_hit ? opi.c : '0;
			OP_MINMAX:
				case (opi.mod)
					MM_MIN:
						if (flags.lt && flags_ac.lt)
							res = opi.a;
						else
							res = flags_bc.lt ? opi.b : opi.c;
					MM_MAX:
						if (!flags.le && !flags_ac.le)
							res = opi.a;
						else
							res = !flags_bc.le ? opi.b : opi.c;
					MM_MINU:
						if (flags.ltu && flags_ac.ltu)
							res = opi.a;
						else
							res = flags_bc.ltu ? opi.b : opi.c;
					MM_MAXU:
						if (!flags.leu && !flags_ac.leu)
							res = opi.a;
						else
							res = !flags_bc.leu ? opi.b : opi.c;
					default: res = '0;
				endcase
			OP_CHK:
				if (!in_range)
					exc = opi.imm[7:0];
			default: res = '0;
		endcase
	end

endmodule

//--- design/alu_mul.sv
// Pipelined multiplier returning the low word of the product
// Latency is ALU_MUL_STAGES cycles from start; a new operand pair may enter
// every cycle

`include "alu_config.svh"

module alu_mul (
	input logic clk,
	alu_op_if.unit opi,
	input logic start,
	output logic [`ALU_WID-1:0] prod
);

	localparam int WID = `ALU_WID;
	localparam int STAGES = `ALU_MUL_STAGES;

	logic [WID-1:0] full;
	logic [WID-1:0] pipe [STAGES];

	// The low word of a product does not depend on operand signedness,
	// so one multiplier serves OP_MUL and OP_MULU
	assign full = opi.a * opi.b;

	// The first stage samples on start; the rest give the multiplier retiming room
	always_ff @(posedge clk)
	begin
		if (start)
			pipe[0] <= full;
		for (int i = 1; i < STAGES; i++)
			pipe[i] <= pipe[i-1];
	end

	assign prod = pipe[STAGES-1];

endmodule

//--- design/alu_div.sv
// Restoring radix-2 divider, one quotient bit per clk
// Results are valid ALU_WID+1 cycles after start and held until the next start
// Signed results truncate toward zero; the remainder follows the dividend sign

`include "alu_config.svh"

module alu_div (
	input logic clk,
	input logic rst,
	alu_op_if.unit opi,
	input logic start,
	output logic [`ALU_WID-1:0] quo,
	output logic [`ALU_WID-1:0] rem,
	output logic dbz
);
	import alu_pkg::*;

	localparam int WID = `ALU_WID;
	localparam int IW = $clog2(WID + 1);

	logic [IW-1:0] iter;
	logic sgn;
	logic neg_a;
	logic neg_b;
	logic [WID-1:0] q_reg;
	logic [WID-1:0] r_reg;
	logic [WID-1:0] d_reg;
	logic neg_q;
	logic neg_r;
	logic [WID:0] r_sh;

	assign sgn = (opi.op == OP_DIV) || (opi.op == OP_MOD);
	assign neg_a = sgn & opi.a[WID-1];
	assign neg_b = sgn & opi.b[WID-1];

	// Partial remainder with the next dividend bit shifted in
	assign r_sh = {r_reg, q_reg[WID-1]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			iter <= '0;
			dbz <= 1'b0;
		end
		else if (start)
		begin
			iter <= IW'(WID);
			dbz <= (opi.b == '0);
		end
		else if (iter != '0)
			iter <= iter - 1'b1;
	end

	// ========================================
	// Shift-subtract datapath
	// ========================================
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			q_reg <= neg_a ? -opi.a : opi.a;
			d_reg <= neg_b ? -opi.b : opi.b;
			r_reg <= '0;
			neg_q <= neg_a ^ neg_b;
			neg_r <= neg_a;
		end
		else if (iter != '0)
		begin
			if (r_sh >= {1'b0, d_reg})
			begin
				r_reg <= WID'(r_sh - {1'b0, d_reg});
				q_reg <= {q_reg[WID-2:0], 1'b1};
			end
			else
			begin
				r_reg <= r_sh[WID-1:0];
				q_reg <= {q_reg[WID-2:0], 1'b0};
			end
		end
	end

	// With a zero divisor every trial subtract succeeds, so the dividend
	// magnitude ends up whole in r_reg and the sign fix restores the dividend
	assign quo = dbz ? '1 : (neg_q ? -q_reg : q_reg);
	assign rem = neg_r ? -r_reg : r_reg;

	// The FSM holds off new divides until the running one has been collected
	a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> iter == '0)
		else $error("divider restarted during an iteration");

endmodule

//--- design/alu_cycle_counter.sv
// Down-counter that times multicycle operations
// zero rises init cycles after load; init must be at least 1

module alu_cycle_counter (
	input logic clk,
	input logic rst,
	input logic load,
	input logic [5:0] init,
	output logic zero
);

	logic [5:0] cnt;

	// The load cycle itself counts as the first of the init cycles
	always_ff @(posedge clk)
	begin
		if (rst)
			cnt <= '0;
		else if (load)
			cnt <= init - 6'd1;
		else if (cnt != '0)
			cnt <= cnt - 6'd1;
	end

	assign zero = (cnt == '0);

endmodule

//--- design/alu_issue_fsm.sv
// Issue control, result select and done generation
// No back-pressure: ld is only legal while busy is low
// An ld in the cycle where done is high would stretch done and is not allowed
// o and exc hold their values until the next done

`include "alu_config.svh"

module alu_issue_fsm (
	input logic clk,
	input logic rst,
	input logic ld,
	alu_op_if.unit opi,
	input logic [`ALU_WID-1:0] logic_res,
	input alu_pkg::exc_t logic_exc,
	input logic [`ALU_WID-1:0] prod,
	input logic [`ALU_WID-1:0] quo,
	input logic [`ALU_WID-1:0] rem,
	input logic dbz,
	input logic cnt_zero,
	output logic mul_start,
	output logic div_start,
	output logic cnt_load,
	output logic [5:0] cnt_init,
	output logic [`ALU_WID-1:0] o,
	output alu_pkg::exc_t exc,
	output logic done,
	output logic busy
);
	import alu_pkg::*;

	alu_state_e state;
	logic is_mul;
	logic is_div;
	logic issue;
	logic want_rem;

	assign is_mul = opi.op inside {OP_MUL, OP_MULU};
	assign is_div = opi.op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
	assign issue = ld && (state == S_IDLE);
	assign mul_start = issue && is_mul;
	assign div_start = issue && is_div;
	assign cnt_load = mul_start || div_start;

	// Wait until the cycle in which the unit output is valid
	assign cnt_init = is_mul ? 6'(`ALU_MUL_STAGES) : 6'(`ALU_WID + 1);
	assign busy = (state != S_IDLE);

	// ========================================
	// State and control
	// ========================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			done <= 1'b0;
			exc <= EXC_NONE;
			want_rem <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				S_IDLE:
					if (mul_start)
						state <= S_WAIT_MUL;
					else if (div_start)
					begin
						state <= S_WAIT_DIV;
						want_rem <= opi.op inside {OP_MOD, OP_MODU};
					end
					else if (ld)
					begin
						exc <= logic_exc;
						done <= 1'b1;
					end
				S_WAIT_MUL:
					if (cnt_zero)
					begin
						exc <= EXC_NONE;
						done <= 1'b1;
						state <= S_IDLE;
					end
				S_WAIT_DIV:
					if (cnt_zero)
					begin
						exc <= dbz ? `ALU_EXC_DBZ : EXC_NONE;
						done <= 1'b1;
						state <= S_IDLE;
					end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue && !is_mul && !is_div)
			o <= logic_res;
		else if ((state == S_WAIT_MUL) && cnt_zero)
			o <= prod;
		else if ((state == S_WAIT_DIV) && cnt_zero)
			o <= want_rem ? rem : quo;
	end

	a_no_ld_busy: assert property (@(posedge clk) disable iff (rst) ld |-> !busy)
		else $error("ld issued while a multicycle operation is in flight");

	// Each operation completes with a single-cycle done pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done high for two consecutive cycles");

endmodule

//--- design/alu_top.sv
// Integer execution lane with single-cycle, multiply and divide paths
// Operands are sampled only in the ld cycle
// ld while busy is high is not allowed

`include "alu_config.svh"

module alu_top (
	input logic clk,
	input logic rst,
	input logic ld,
	input alu_pkg::alu_op_e op,
	input alu_pkg::alu_mod_t mod,
	input logic [`ALU_WID-1:0] a,
	input logic [`ALU_WID-1:0] b,
	input logic [`ALU_WID-1:0] c,
	input logic [`ALU_WID-1:0] imm,
	output logic [`ALU_WID-1:0] o,
	output alu_pkg::exc_t exc,
	output logic done,
	output logic busy
);
	import alu_pkg::*;

	logic [`ALU_WID-1:0] logic_res;
	exc_t logic_exc;
	logic [`ALU_WID-1:0] prod;
	logic [`ALU_WID-1:0] quo;
	logic [`ALU_WID-1:0] rem;
	logic dbz;
	logic mul_start;
	logic div_start;
	logic cnt_load;
	logic [5:0] cnt_init;
	logic cnt_zero;

	alu_op_if op_if ();

	assign op_if.op = op;
	assign op_if.mod = mod;
	assign op_if.a = a;
	assign op_if.b = b;
	assign op_if.c = c;
	assign op_if.imm = imm;

	alu_logic logic_i (.opi(op_if.unit), .res(logic_res), .exc(logic_exc));

	alu_mul mul_i (.clk(clk), .opi(op_if.unit), .start(mul_start), .prod(prod));

	alu_div div_i (
		.clk(clk), .rst(rst), .opi(op_if.unit), .start(div_start),
		.quo(quo), .rem(rem), .dbz(dbz)
	);

	alu_cycle_counter cnt_i (
		.clk(clk), .rst(rst), .load(cnt_load), .init(cnt_init), .zero(cnt_zero)
	);

	alu_issue_fsm fsm_i (
		.clk(clk), .rst(rst), .ld(ld), .opi(op_if.unit),
		.logic_res(logic_res), .logic_exc(logic_exc),
		.prod(prod), .quo(quo), .rem(rem), .dbz(dbz), .cnt_zero(cnt_zero),
		.mul_start(mul_start), .div_start(div_start),
		.cnt_load(cnt_load), .cnt_init(cnt_init),
		.o(o), .exc(exc), .done(done), .busy(busy)
	);

endmodule

//--- verif/alu_tb.sv
// Self-checking testbench for the ALU lane
// Operand words are built from two 32-bit LCG draws, so ALU_WID may not exceed 64
// The bounds check is exercised with unsigned ranges that do not wrap
// Only the modifier codes defined for each operation are issued

`include "alu_config.svh"

module alu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import alu_pkg::*;

	localparam int W = `ALU_WID;
	localparam int N_OPS = 80 + 250 + 20 + 56 + 12 + 48;
	localparam int CYCLE_LIMIT = N_OPS * (W + 4) + 100;

	logic clk;
	logic rst;
	logic ld;
	alu_op_e op;
	alu_mod_t mod;
	logic [W-1:0] a;
	logic [W-1:0] b;
	logic [W-1:0] c;
	logic [W-1:0] imm;
	logic [W-1:0] o;
	exc_t exc;
	logic done;
	logic busy;

	logic [31:0] lcg_state = 32'h3a35_d211;
	logic [W+7:0] exp_q [$];
	alu_op_e op_q [$];
	logic [W+7:0] exp_word;
	alu_op_e exp_op;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	alu_top dut_i (
		.clk(clk), .rst(rst), .ld(ld), .op(op), .mod(mod),
		.a(a), .b(b), .c(c), .imm(imm),
		.o(o), .exc(exc), .done(done), .busy(busy)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// ========================================
	// Stimulus helpers
	// ========================================
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [W-1:0] rand_word();
		logic [63:0] r;
		r = {next_rand(), next_rand()};
		return r[W-1:0];
	endfunction

	// Operands that separate signed from unsigned ordering
	function automatic logic [W-1:0] edge_value(int k);
		case (k)
			0: return '0;
			1: return W'(1);
			2: return '1;
			3: return {1'b1, {(W-1){1'b0}}};
			default: return {1'b0, {(W-1){1'b1}}};
		endcase
	endfunction

	function automatic int latency_of(alu_op_e kind);
		if (kind inside {OP_MUL, OP_MULU})
			return `ALU_MUL_STAGES + 1;
		if (kind inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU})
			return W + 2;
		return 1;
	endfunction

	// Three-way min or max; flipping the top bit turns a signed order into an unsigned one
	function automatic logic [W-1:0] pick3(logic [W-1:0] va, logic [W-1:0] vb,
		logic [W-1:0] vc, logic want_max, logic signed_cmp);
		logic [W-1:0] flip;
		logic [W-1:0] best;
		flip = signed_cmp ? {1'b1, {(W-1){1'b0}}} : '0;
		best = va;
		if (want_max ? ((vb ^ flip) > (best ^ flip)) : ((vb ^ flip) < (best ^ flip)))
			best = vb;
		if (want_max ? ((vc ^ flip) > (best ^ flip)) : ((vc ^ flip) < (best ^ flip)))
			best = vc;
		return best;
	endfunction

	// ========================================
	// Reference model, returns {exc, result}
	// ========================================
	function automatic logic [W+7:0] ref_alu(alu_op_e kind, alu_mod_t modf,
		logic [W-1:0] va, logic [W-1:0] vb, logic [W-1:0] vc, logic [W-1:0] vimm);
		logic signed [2*W-1:0] sa;
		logic signed [2*W-1:0] sb;
		logic [2*W-1:0] ua;
		logic [2*W-1:0] ub;
		logic [2*W-1:0] wide;
		logic [W-1:0] p;
		logic [W-1:0] r;
		exc_t e;
		logic hold;
		sa = {{W{va[W-1]}}, va};
		sb = {{W{vb[W-1]}}, vb};
		ua = {{W{1'b0}}, va};
		ub = {{W{1'b0}}, vb};
		r = '0;
		e = '0;
		hold = 1'b0;
		case (kind)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
			begin
				case (kind)
					OP_ADD: p = va + vb;
					OP_SUB: p = va - vb;
					OP_AND: p = va & vb;
					OP_OR: p = va | vb;
					default: p = va ^ vb;
				endcase
				case (modf)
					3'd0: r = p & vc;
					3'd1: r = p & ~vc;
					3'd2: r = p | vc;
					3'd3: r = p ^ vc;
					3'd4: r = (kind == OP_SUB) ? p - vc : p + vc;
					default: r = p;
				endcase
			end
			OP_SET:
			begin
				case (modf)
					3'd0: hold = (va == vb);
					3'd1: hold = (va != vb);
					3'd2: hold = ($signed(va) < $signed(vb));
					3'd3: hold = ($signed(va) <= $signed(vb));
					3'd4: hold = (va < vb);
					3'd5: hold = (va <= vb);
					default: hold = 1'b0;
				endcase
				r = hold ? vc : '0;
			end
			OP_MINMAX:
				r = pick3(va, vb, vc, modf[0], !modf[1]);
			OP_MUL:
			begin
				wide = sa * sb;
				r = wide[W-1:0];
			end
			OP_MULU:
			begin
				wide = ua * ub;
				r = wide[W-1:0];
			end
			OP_DIV, OP_DIVU, OP_MOD, OP_MODU:
				if (vb == '0)
				begin
					r = (kind inside {OP_DIV, OP_DIVU}) ? '1 : va;
					e = `ALU_EXC_DBZ;
				end
				else
				begin
					case (kind)
						OP_DIV: wide = sa / sb;
						OP_MOD: wide = sa % sb;
						OP_DIVU: wide = ua / ub;
						default: wide = ua % ub;
					endcase
					r = wide[W-1:0];
				end
			OP_CHK:
			begin
				hold = (modf == 3'd0) ? (va >= vb && va < vc) : (va >= vb && va <= vc);
				if (!hold)
					e = vimm[7:0];
			end
			default: r = '0;
		endcase
		return {e, r};
	endfunction

	// Issues one operation, then waits for done and checks latency and busy
	task automatic issue(alu_op_e kind, alu_mod_t modf, logic [W-1:0] va,
		logic [W-1:0] vb, logic [W-1:0] vc, logic [W-1:0] vimm);
		int lat;
		int want;
		logic seen;
		logic busy_lost;
		want = latency_of(kind);
		exp_q.push_back(ref_alu(kind, modf, va, vb, vc, vimm));
		op_q.push_back(kind);
		@(posedge clk);
		ld <= 1'b1;
		op <= kind;
		mod <= modf;
		a <= va;
		b <= vb;
		c <= vc;
		imm <= vimm;
		@(posedge clk);
		ld <= 1'b0;
		// Operands are garbage after the issue cycle
		a <= rand_word();
		b <= rand_word();
		c <= rand_word();
		lat = 0;
		seen = 1'b0;
		busy_lost = 1'b0;
		while (!seen && lat < want + 8)
		begin
			@(negedge clk);
			lat++;
			if (done)
				seen = 1'b1;
			else if (!busy)
				busy_lost = 1'b1;
		end
		checks++;
		if (!seen)
		begin
			$display("No done for op %0d within %0d cycles at %0t", kind, lat, $time);
			errors++;
		end
		else if (lat != want)
		begin
			$display("Mismatch at %0t: op %0d done after %0d cycles, expected %0d",
				$time, kind, lat, want);
			errors++;
		end
		if (busy_lost)
		begin
			$display("busy dropped before done for op %0d at %0t", kind, $time);
			errors++;
		end
	endtask

	task automatic finish_test(string name, int ops, int err_start);
		$display("Test %s: %0d operations, %0d errors", name, ops, errors - err_start);
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic test_single_cycle();
		int e0;
		logic [W-1:0] va;
		e0 = errors;
		@(negedge clk);
		checks++;
		if (done !== 1'b0 || busy !== 1'b0 || exc !== '0)
		begin
			$display("Mismatch at %0t: done, busy or exc not zero after reset", $time);
			errors++;
		end
		for (int k = 0; k < 5; k++)
			for (int m = 0; m < 6; m++)
				for (int rep = 0; rep < 2; rep++)
					issue(alu_op_e'(k), alu_mod_t'((m < 5) ? m : 7), rand_word(), rand_word(),
						rand_word(), '0);
		for (int s = 0; s < 6; s++)
			for (int rep = 0; rep < 2; rep++)
			begin
				va = rand_word();
				issue(OP_SET, alu_mod_t'(s), va, (rep == 0) ? va : rand_word(), rand_word(), '0);
			end
		for (int m = 0; m < 4; m++)
			for (int rep = 0; rep < 2; rep++)
				issue(OP_MINMAX, alu_mod_t'(m), rand_word(), rand_word(), rand_word(), '0);
		finish_test("single_cycle", 80, e0);
	endtask

	task automatic test_compare_edges();
		int e0;
		e0 = errors;
		for (int i = 0; i < 5; i++)
			for (int j = 0; j < 5; j++)
			begin
				for (int s = 0; s < 6; s++)
					issue(OP_SET, alu_mod_t'(s), edge_value(i), edge_value(j), rand_word(), '0);
				for (int m = 0; m < 4; m++)
					issue(OP_MINMAX, alu_mod_t'(m), edge_value(i), edge_value(j),
						edge_value((i + j) % 5), '0);
			end
		finish_test("compare_edges", 250, e0);
	endtask

	task automatic test_multiply();
		int e0;
		e0 = errors;
		for (int i = 0; i < 20; i++)
			issue(i[0] ? OP_MULU : OP_MUL, MOD_NONE, rand_word(), rand_word(), '0, '0);
		finish_test("multiply", 20, e0);
	endtask

	task automatic test_divide();
		int e0;
		logic [31:0] t;
		logic [W-1:0] vb;
		e0 = errors;
		for (int i = 0; i < 40; i++)
		begin
			t = next_rand();
			// A shifted divisor spreads the quotient sizes
			vb = rand_word() >> (t % W);
			if (t[8])
				vb = -vb;
			if (vb == '0)
				vb = W'(1);
			issue(alu_op_e'(int'(OP_DIV) + i % 4), MOD_NONE, rand_word(), vb, '0, '0);
		end
		for (int k = 0; k < 4; k++)
		begin
			issue(alu_op_e'(int'(OP_DIV) + k), MOD_NONE, edge_value(3), '1, '0, '0);
			issue(alu_op_e'(int'(OP_DIV) + k), MOD_NONE, -W'(7), W'(2), '0, '0);
			issue(alu_op_e'(int'(OP_DIV) + k), MOD_NONE, W'(7), -W'(2), '0, '0);
			issue(alu_op_e'(int'(OP_DIV) + k), MOD_NONE, -W'(7), -W'(2), '0, '0);
		end
		finish_test("divide", 56, e0);
	endtask

	task automatic test_divide_by_zero();
		int e0;
		e0 = errors;
		for (int k = 0; k < 4; k++)
		begin
			issue(alu_op_e'(int'(OP_DIV) + k), MOD_NONE, rand_word(), '0, '0, '0);
			issue(alu_op_e'(int'(OP_DIV) + k), MOD_NONE, edge_value(3), '0, '0, '0);
			issue(alu_op_e'(int'(OP_DIV) + k), MOD_NONE, -W'(5), '0, '0, '0);
		end
		finish_test("divide_by_zero", 12, e0);
	endtask

	task automatic test_bounds_check();
		int e0;
		logic [W-1:0] lo;
		logic [W-1:0] hi;
		logic [W-1:0] probe [6];
		e0 = errors;
		for (int r = 0; r < 4; r++)
		begin
			lo = W'(16 + next_rand() % 1024);
			hi = lo + W'(2 + next_rand() % 1024);
			probe = '{lo - 1, lo, lo + 1, hi - 1, hi, hi + 1};
			for (int m = 0; m < 2; m++)
				for (int v = 0; v < 6; v++)
					issue(OP_CHK, alu_mod_t'(m), probe[v], lo, hi, rand_word() | W'(1));
		end
		finish_test("bounds_check", 48, e0);
	endtask

	// ========================================
	// Result compare and watchdog
	// ========================================
	always @(negedge clk)
	begin
		if (!rst && done)
		begin
			if (exp_q.size() == 0)
			begin
				$display("done pulsed with no operation outstanding at %0t", $time);
				errors++;
			end
			else
			begin
				exp_word = exp_q.pop_front();
				exp_op = op_q.pop_front();
				checks++;
				if (o !== exp_word[W-1:0] || exc !== exp_word[W+7:W])
				begin
					$display("Mismatch at %0t: op %0d gave o=%h exc=%h, expected o=%h exc=%h",
						$time, exp_op, o, exc, exp_word[W-1:0], exp_word[W+7:W]);
					errors++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		rst = 1'b1;
		ld = 1'b0;
		op = OP_ADD;
		mod = MOD_NONE;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_single_cycle();
		test_compare_edges();
		test_multiply();
		test_divide();
		test_divide_by_zero();
		test_bounds_check();
		repeat (4) @(negedge clk);
		if (exp_q.size() != 0)
		begin
			$display("%0d issued operations never completed", exp_q.size());
			errors++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- alu_unit.f
+incdir+design
design/alu_pkg.sv
design/alu_op_if.sv
design/alu_cmp.sv
design/alu_logic.sv
design/alu_mul.sv
design/alu_div.sv
design/alu_cycle_counter.sv
design/alu_issue_fsm.sv
design/alu_top.sv
verif/alu_tb.sv
